/* tb/cnn_stim.hex */
// 16-bit words in hex; @000 matrices (size word, then one pixel row per line)
// @400 kernel words (even tap high byte), @800 expected word count then output words
@000
// 4x4
0004
0000 0000
0A00 0000
0000 0002
0000 0000
// 6x6
0006
0000 0000 0000
0000 FC00 0000
0300 0000 0000
0000 0000 0000
0000 0000 00EC
6400 0000 0000
// 8x8
0008
0000 0000 0000 0000
0000 0000 0000 0000
0000 0000 0000 0000
0000 0900 0000 0000
0000 0000 0000 0000
0000 0000 0000 0000
7F00 0000 0000 0000
0000 0000 0000 CE00
// Terminator
FFFF
@400
0102 0304 0506 0708 FF00
@800
0008
3800
1800 7F14
0048 0036 2D00 7F00 3200

/* cnn_accel.f */
+incdir+design
design/cnn_mem_pkg.sv
design/cnn_pix_pkg.sv
design/kernel_regs.sv
design/window_fetch.sv
design/conv_pool.sv
design/out_packer.sv
design/cnn_top.sv
tb/cnn_checker.sv
tb/cnn_tb.sv

/* Bender.yml */
package:
  name: cnn_accel

sources:
  - include_dirs:
      - design
    files:
      - design/cnn_mem_pkg.sv
      - design/cnn_pix_pkg.sv
      - design/kernel_regs.sv
      - design/window_fetch.sv
      - design/conv_pool.sv
      - design/out_packer.sv
      - design/cnn_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/cnn_checker.sv
      - tb/cnn_tb.sv

/* tb/cnn_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cnn_cfg.svh"

module cnn_tb
	import cnn_mem_pkg::*;
();
	localparam logic [`CNN_ADDR_W-1:0] WEIGHT_BASE = 12'h400;
	localparam logic [`CNN_ADDR_W-1:0] EXP_BASE    = 12'h800;
	localparam int RUNS            = 2;
	localparam int CYCLES_PER_WORD = 40;
	localparam int SLACK_CYCLES    = 500;

	logic                   clk;
	logic                   reset_b;
	logic                   run;
	logic                   busy;
	logic [`CNN_ADDR_W-1:0] in_rd_addr;
	logic [`CNN_DATA_W-1:0] in_rd_data;
	logic [`CNN_ADDR_W-1:0] weights_rd_addr;
	logic [`CNN_DATA_W-1:0] weights_rd_data;
	sram_wr_t               out_wr;
	logic [`CNN_DATA_W-1:0] mem [0:4095];
	logic [`CNN_ADDR_W-1:0] exp_idx;
	logic [`CNN_DATA_W-1:0] exp_count;
	logic [`CNN_DATA_W-1:0] exp_word;
	int                     value_errors;
	int                     ctrl_errors;
	int                     cycle_budget = 0;

	cnn_top DUT (
		.clk             (clk),
		.reset_b         (reset_b),
		.run             (run),
		.busy            (busy),
		.in_rd_addr      (in_rd_addr),
		.in_rd_data      (in_rd_data),
		.weights_rd_addr (weights_rd_addr),
		.weights_rd_data (weights_rd_data),
		.out_wr          (out_wr)
	);

	cnn_checker u_check (
		.clk          (clk),
		.reset_b      (reset_b),
		.run          (run),
		.busy         (busy),
		.out_wr       (out_wr),
		.exp_count    (exp_count),
		.exp_word     (exp_word),
		.exp_idx      (exp_idx),
		.value_errors (value_errors),
		.ctrl_errors  (ctrl_errors)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	// --------------------
	// SRAM models
	// --------------------
	// Both models read the shared array with one cycle of latency
	always @(posedge clk) begin
		in_rd_data      <= mem[in_rd_addr];
		weights_rd_data <= mem[WEIGHT_BASE + weights_rd_addr];
	end

	assign exp_count = mem[EXP_BASE];
	assign exp_word  = mem[EXP_BASE + 12'd1 + exp_idx];

	// Walk the size words up to the terminator
	function automatic int count_input_words();
		int addr;
		addr = 0;
		while (addr < WEIGHT_BASE && mem[addr] !== `CNN_SIZE_END)
			addr += mem[addr][7:0] * mem[addr][7:0] / 2 + 1;
		return addr + 1;
	endfunction

	task automatic start_run();
		@(posedge clk);
		run <= 1'b1;
		@(posedge clk);
		run <= 1'b0;
	endtask

	task automatic wait_idle();
		@(negedge clk);
		while (busy)
			@(negedge clk);
	endtask

	// --------------------
	// Watchdog
	// --------------------
	initial begin
		wait (cycle_budget != 0);
		repeat (cycle_budget) @(posedge clk);
		$display("Timeout: busy still high after %0d cycles", cycle_budget);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		reset_b         = 1'b0;
		run             = 1'b0;
		in_rd_data      = '0;
		weights_rd_data = '0;
		$readmemh("tb/cnn_stim.hex", mem);
		cycle_budget = RUNS * CYCLES_PER_WORD * count_input_words() + SLACK_CYCLES;
		repeat (4) @(posedge clk);
		reset_b <= 1'b1;
		// Second run must restart at output address 0
		for (int i = 0; i < RUNS; i++) begin
			start_run();
			wait_idle();
			repeat (5) @(posedge clk);
		end
		$display("Errors: value %0d, control %0d", value_errors, ctrl_errors);
		if (value_errors == 0 && ctrl_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/cnn_checker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cnn_cfg.svh"

module cnn_checker
	import cnn_mem_pkg::*;
(
	input  wire                    clk,
	input  wire                    reset_b,
	input  wire                    run,
	input  wire                    busy,
	input  wire sram_wr_t          out_wr,
	input  wire  [`CNN_DATA_W-1:0] exp_count,
	input  wire  [`CNN_DATA_W-1:0] exp_word,
	output logic [`CNN_ADDR_W-1:0] exp_idx,
	output int                     value_errors,
	output int                     ctrl_errors
);
	int   wr_count;
	logic prev_run;
	logic prev_busy;

	// Expected word for the next write of this run
	assign exp_idx = `CNN_ADDR_W'(wr_count);

	task automatic compare_write();
		if (out_wr.addr !== `CNN_ADDR_W'(wr_count)) begin
			$display("ERROR out_wr.addr: expected %h, got %h",
				`CNN_ADDR_W'(wr_count), out_wr.addr);
			value_errors++;
		end
		if (out_wr.data !== exp_word) begin
			$display("ERROR out_wr.data: expected %h, got %h", exp_word, out_wr.data);
			value_errors++;
		end
	endtask

	// Sampled away from the rising edge
	always @(negedge clk) begin
		if (!reset_b) begin
			wr_count     = 0;
			prev_run     = 1'b0;
			prev_busy    = 1'b0;
			value_errors = 0;
			ctrl_errors  = 0;
		end else begin
			if (prev_run && !prev_busy && !busy) begin
				$display("Busy did not rise the cycle after run at %0t", $time);
				ctrl_errors++;
			end
			if (busy && !prev_busy)
				wr_count = 0;
			if (out_wr.en) begin
				if (!busy) begin
					$display("Output write while busy is low at %0t", $time);
					ctrl_errors++;
				end else if (wr_count >= exp_count) begin
					$display("More output writes than expected at %0t", $time);
					ctrl_errors++;
				end else begin
					compare_write();
				end
				wr_count++;
			end
			// Every word must be out when busy falls
			if (!busy && prev_busy && wr_count != exp_count) begin
				$display("ERROR out_wr write count: expected %h, got %h", exp_count, wr_count);
				value_errors++;
			end
			prev_run  = run;
			prev_busy = busy;
		end
	end

endmodule

`default_nettype wire

/* design/cnn_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cnn_cfg.svh"

module cnn_top
	import cnn_mem_pkg::*;
	import cnn_pix_pkg::*;
(
	input  wire                    clk,
	input  wire                    reset_b,
	input  wire                    run,
	output logic                   busy,
	output logic [`CNN_ADDR_W-1:0] in_rd_addr,
	input  wire  [`CNN_DATA_W-1:0] in_rd_data,
	output logic [`CNN_ADDR_W-1:0] weights_rd_addr,
	input  wire  [`CNN_DATA_W-1:0] weights_rd_data,
	output sram_wr_t               out_wr
);
	logic      run_start;
	patch_t    patch;
	logic      patch_valid;
	logic      patch_ready;
	logic      conv_idle;
	kernel_t   kernel;
	logic      kernel_valid;
	pool_res_t res;
	logic      res_valid;

	window_fetch u_fetch (
		.clk         (clk),
		.reset_b     (reset_b),
		.run         (run),
		.busy        (busy),
		.run_start   (run_start),
		.in_rd_addr  (in_rd_addr),
		.in_rd_data  (in_rd_data),
		.patch_ready (patch_ready),
		.conv_idle   (conv_idle),
		.patch       (patch),
		.patch_valid (patch_valid)
	);

	kernel_regs u_kernel (
		.clk             (clk),
		.reset_b         (reset_b),
		.run_start       (run_start),
		.weights_rd_addr (weights_rd_addr),
		.weights_rd_data (weights_rd_data),
		.kernel          (kernel),
		.kernel_valid    (kernel_valid)
	);

	conv_pool u_conv (
		.clk          (clk),
		.reset_b      (reset_b),
		.patch        (patch),
		.patch_valid  (patch_valid),
		.kernel       (kernel),
		.kernel_valid (kernel_valid),
		.patch_ready  (patch_ready),
		.conv_idle    (conv_idle),
		.res          (res),
		.res_valid    (res_valid)
	);

	out_packer u_pack (
		.clk       (clk),
		.reset_b   (reset_b),
		.run_start (run_start),
		.res       (res),
		.res_valid (res_valid),
		.out_wr    (out_wr)
	);

endmodule

`default_nettype wire

/* design/out_packer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cnn_cfg.svh"

module out_packer
	import cnn_mem_pkg::*;
	import cnn_pix_pkg::*;
(
	input  wire            clk,
	input  wire            reset_b,
	input  wire            run_start,
	input  wire pool_res_t res,
	input  wire            res_valid,
	output sram_wr_t       out_wr
);
	logic                   have_hi;
	logic [`CNN_PIX_W-1:0]  hi_byte;
	logic [`CNN_ADDR_W-1:0] next_addr;
	logic                   wr_en;
	logic [`CNN_ADDR_W-1:0] wr_addr;
	logic [`CNN_DATA_W-1:0] wr_data;
	logic                   pair_done;
	logic                   flush;

	assign pair_done = res_valid && have_hi;
	// Last result of an odd count goes out alone
	assign flush     = res_valid && !have_hi && res.last;
	assign out_wr    = '{en: wr_en, addr: wr_addr, data: wr_data};

	always_ff @(posedge clk) begin
		if (!reset_b) begin
			have_hi   <= 1'b0;
			next_addr <= '0;
			wr_en     <= 1'b0;
		end else begin
			wr_en <= pair_done || flush;
			if (res_valid)
				have_hi <= !have_hi && !res.last;
			if (run_start)
				next_addr <= '0;
			else if (pair_done || flush)
				next_addr <= next_addr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (res_valid && !have_hi)
			hi_byte <= res.value;
		if (pair_done)
			wr_data <= {hi_byte, res.value};
		else if (flush)
			wr_data <= {res.value, 8'h00};
		if (pair_done || flush)
			wr_addr <= next_addr;
	end

endmodule

`default_nettype wire

/* design/conv_pool.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cnn_cfg.svh"

module conv_pool
	import cnn_pix_pkg::*;
(
	input  wire          clk,
	input  wire          reset_b,
	input  wire patch_t  patch,
	input  wire          patch_valid,
	input  wire kernel_t kernel,
	input  wire          kernel_valid,
	output logic         patch_ready,
	output logic         conv_idle,
	output pool_res_t    res,
	output logic         res_valid
);
	logic                           running;
	logic                           accept;
	logic [3:0]                     tap;
	logic [1:0]                     kcol;
	logic [3:0]                     pbase;
	pix_t [15:0]                    pix_q;
	logic                           last_q;
	acc_t                           acc [4];
	logic signed [2*`CNN_PIX_W-1:0] prod [4];
	acc_t                           max_top;
	acc_t                           max_bot;
	acc_t                           max_all;

	assign patch_ready = kernel_valid && !running;
	assign conv_idle   = !running;
	assign accept      = patch_valid && patch_ready;

	// Lane l covers the window at row l[1], column l[0]
	always_comb begin
		for (int l = 0; l < 4; l++)
			prod[l] = kernel[tap] * pix_q[pbase + 4'({l[1], 1'b0, l[0]})];
	end

	always_ff @(posedge clk) begin
		if (!reset_b) begin
			running   <= 1'b0;
			tap       <= '0;
			kcol      <= '0;
			pbase     <= '0;
			res_valid <= 1'b0;
		end else begin
			res_valid <= 1'b0;
			if (accept) begin
				running <= 1'b1;
				tap     <= '0;
				kcol    <= '0;
				pbase   <= '0;
			end else if (running) begin
				tap <= tap + 4'd1;
				// Wrap to the next kernel row
				if (kcol == 2'd2) begin
					kcol  <= '0;
					pbase <= pbase + 4'd2;
				end else begin
					kcol  <= kcol + 2'd1;
					pbase <= pbase + 4'd1;
				end
				if (tap == 4'(`CNN_KTAPS - 1)) begin
					running   <= 1'b0;
					res_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pix_q  <= patch.pix;
			last_q <= patch.last;
			for (int l = 0; l < 4; l++)
				acc[l] <= '0;
		end else if (running) begin
			for (int l = 0; l < 4; l++)
				acc[l] <= acc[l] + prod[l];
		end
	end

	// --------------------
	// Pool and clip
	// --------------------
	assign max_top = (acc[0] > acc[1]) ? acc[0] : acc[1];
	assign max_bot = (acc[2] > acc[3]) ? acc[2] : acc[3];
	assign max_all = (max_top > max_bot) ? max_top : max_bot;

	always_comb begin
		res.last = last_q;
		if (max_all[`CNN_ACC_W-1])
			res.value = '0;
		else if (max_all > `CNN_RELU_MAX)
			res.value = 8'(`CNN_RELU_MAX);
		else
			res.value = max_all[`CNN_PIX_W-1:0];
	end

endmodule

`default_nettype wire

/* design/window_fetch.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cnn_cfg.svh"

module window_fetch
	import cnn_mem_pkg::*;
	import cnn_pix_pkg::*;
(
	input  wire                    clk,
	input  wire                    reset_b,
	input  wire                    run,
	output logic                   busy,
	output logic                   run_start,
	output logic [`CNN_ADDR_W-1:0] in_rd_addr,
	input  wire sram_word_u        in_rd_data,
	input  wire                    patch_ready,
	input  wire                    conv_idle,
	output patch_t                 patch,
	output logic                   patch_valid
);
	typedef enum logic [2:0] {
		S_IDLE, S_SIZE, S_CHECK, S_FETCH, S_LAST, S_HOLD, S_DRAIN, S_FLUSH
	} state_t;

	state_t                 state;
	logic [7:0]             n;
	logic [7:0]             row;
	logic [7:0]             col;
	logic [`CNN_ADDR_W-1:0] base;
	logic [`CNN_ADDR_W-1:0] row_addr;
	logic [`CNN_ADDR_W-1:0] rd_addr;
	logic [`CNN_ADDR_W-1:0] n_words;
	logic [`CNN_ADDR_W-1:0] half_n;
	logic [2:0]             wcnt;
	logic                   cap_en;
	logic [2:0]             cap_idx;
	logic                   col_end;
	logic                   last_patch;
	logic                   xfer;
	logic                   is_end;

	assign busy       = (state != S_IDLE);
	assign in_rd_addr = (state == S_FETCH) ? rd_addr : base;
	assign n_words    = `CNN_ADDR_W'(n);
	assign half_n     = `CNN_ADDR_W'(n[7:1]);
	assign col_end    = (col == n - 8'd4);
	assign last_patch = col_end && (row == n - 8'd4);
	assign xfer       = patch_valid && patch_ready;
	assign is_end     = (in_rd_data.size == `CNN_SIZE_END);

	// --------------------
	// Sequencing
	// --------------------
	always_ff @(posedge clk) begin
		if (!reset_b) begin
			state       <= S_IDLE;
			patch_valid <= 1'b0;
			run_start   <= 1'b0;
			wcnt        <= '0;
			cap_en      <= 1'b0;
			cap_idx     <= '0;
		end else begin
			run_start <= 1'b0;
			cap_en    <= (state == S_FETCH);
			cap_idx   <= wcnt;
			case (state)
				S_IDLE: begin
					if (run) begin
						state     <= S_SIZE;
						run_start <= 1'b1;
					end
				end
				S_SIZE:  state <= S_CHECK;
				S_CHECK: state <= is_end ? S_DRAIN : S_FETCH;
				S_FETCH: begin
					wcnt <= wcnt + 3'd1;
					if (wcnt == 3'(`CNN_PATCH_WORDS - 1))
						state <= S_LAST;
				end
				// Eighth word lands this cycle
				S_LAST: begin
					patch_valid <= 1'b1;
					state       <= S_HOLD;
				end
				S_HOLD: begin
					if (xfer) begin
						patch_valid <= 1'b0;
						state       <= last_patch ? S_SIZE : S_FETCH;
					end
				end
				S_DRAIN: begin
					if (conv_idle)
						state <= S_FLUSH;
				end
				// Room for the packer's final write
				S_FLUSH: state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// --------------------
	// Matrix walk
	// --------------------
	always_ff @(posedge clk) begin
		case (state)
			S_IDLE: base <= '0;
			S_CHECK: begin
				n        <= in_rd_data.size[7:0];
				row      <= '0;
				col      <= '0;
				row_addr <= base + 1'b1;
				rd_addr  <= base + 1'b1;
			end
			// Two words per patch row, then down one image row
			S_FETCH: rd_addr <= wcnt[0] ? rd_addr + half_n - 1'b1 : rd_addr + 1'b1;
			S_HOLD: begin
				if (xfer) begin
					if (last_patch) begin
						base <= row_addr + (n_words << 1);
					end else if (col_end) begin
						row      <= row + 8'd2;
						col      <= '0;
						row_addr <= row_addr + n_words;
						rd_addr  <= row_addr + n_words;
					end else begin
						col     <= col + 8'd2;
						rd_addr <= row_addr + `CNN_ADDR_W'(col[7:1]) + 1'b1;
					end
				end
			end
			default: ;
		endcase
	end

	// Low byte is the even column
	always_ff @(posedge clk) begin
		if (cap_en) begin
			patch.pix[{cap_idx, 1'b0}] <= in_rd_data.pix_pair.lo;
			patch.pix[{cap_idx, 1'b1}] <= in_rd_data.pix_pair.hi;
		end
		if (state == S_LAST)
			patch.last <= last_patch;
	end

endmodule

`default_nettype wire

/* design/kernel_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cnn_cfg.svh"

module kernel_regs
	import cnn_mem_pkg::*;
	import cnn_pix_pkg::*;
(
	input  wire                    clk,
	input  wire                    reset_b,
	input  wire                    run_start,
	output logic [`CNN_ADDR_W-1:0] weights_rd_addr,
	input  wire sram_word_u        weights_rd_data,
	output kernel_t                kernel,
	output logic                   kernel_valid
);
	logic       reading;
	logic       rd_now;
	logic [2:0] rd_cnt;
	logic       cap_en;
	logic [2:0] cap_idx;

	// First word goes out in the run_start cycle itself
	assign rd_now = run_start || reading;
	assign weights_rd_addr = `CNN_ADDR_W'(rd_cnt);

	always_ff @(posedge clk) begin
		if (!reset_b) begin
			reading      <= 1'b0;
			rd_cnt       <= '0;
			cap_en       <= 1'b0;
			cap_idx      <= '0;
			kernel_valid <= 1'b0;
		end else begin
			cap_en  <= rd_now;
			cap_idx <= rd_cnt;
			if (rd_now) begin
				if (rd_cnt == 3'(`CNN_KWORDS - 1)) begin
					reading <= 1'b0;
					rd_cnt  <= '0;
				end else begin
					reading <= 1'b1;
					rd_cnt  <= rd_cnt + 3'd1;
				end
			end
			if (run_start)
				kernel_valid <= 1'b0;
			else if (cap_en && cap_idx == 3'(`CNN_KWORDS - 1))
				kernel_valid <= 1'b1;
		end
	end

	// Even tap in the high byte; the last word carries only tap 8
	always_ff @(posedge clk) begin
		if (cap_en) begin
			kernel[{cap_idx, 1'b0}] <= weights_rd_data.pix_pair.hi;
			if (cap_idx != 3'(`CNN_KWORDS - 1))
				kernel[{cap_idx, 1'b1}] <= weights_rd_data.pix_pair.lo;
		end
	end

endmodule

`default_nettype wire

/* design/cnn_pix_pkg.sv */
`default_nettype none
`include "cnn_cfg.svh"

package cnn_pix_pkg;

	typedef logic signed [`CNN_PIX_W-1:0] pix_t;
	typedef logic signed [`CNN_ACC_W-1:0] acc_t;

	// Taps in row-major order, tap 0 at index 0
	typedef pix_t [`CNN_KTAPS-1:0] kernel_t;

	// 4x4 patch, pixel (r,c) at index r*4+c
	typedef struct packed {
		pix_t [15:0] pix;
		logic        last;
	} patch_t;

	// Clipped max of one patch
	typedef struct packed {
		logic [`CNN_PIX_W-1:0] value;
		logic                  last;
	} pool_res_t;

endpackage

`default_nettype wire

/* design/cnn_mem_pkg.sv */
`default_nettype none
`include "cnn_cfg.svh"

package cnn_mem_pkg;

	// Two pixels in one SRAM word
	typedef struct packed {
		logic [`CNN_PIX_W-1:0] hi;
		logic [`CNN_PIX_W-1:0] lo;
	} pix_pair_t;

	// Input word is either a size header or a pixel pair
	typedef union packed {
		logic [`CNN_DATA_W-1:0] size;
		pix_pair_t              pix_pair;
	} sram_word_u;

	typedef struct packed {
		logic                   en;
		logic [`CNN_ADDR_W-1:0] addr;
		logic [`CNN_DATA_W-1:0] data;
	} sram_wr_t;

endpackage

`default_nettype wire

/* design/cnn_cfg.svh */
`ifndef CNN_CFG_SVH
`define CNN_CFG_SVH

// SRAM geometry
`define CNN_ADDR_W 12
`define CNN_DATA_W 16

// Arithmetic widths
`define CNN_PIX_W 8
`define CNN_ACC_W 20

// Kernel and patch shape
`define CNN_KTAPS 9
`define CNN_KWORDS 5
`define CNN_PATCH_WORDS 8

// Size word that ends the matrix sequence
`define CNN_SIZE_END 16'hFFFF
`define CNN_RELU_MAX 127

`endif
